/* hw/csr_addr_pkg.sv */
`default_nettype none

package csr_addr_pkg;

  // ----------------------------------------------------------
  // Register map geometry
  // ----------------------------------------------------------
  parameter int unsigned CsrDataWidth = 32;
  parameter int unsigned CsrAddrWidth = 6;   // Word index
  parameter int unsigned NumRegs      = 11;

  // Word-indexed register addresses
  parameter logic [CsrAddrWidth-1:0] CORE_SET_ADDR         = 6'd0;
  parameter logic [CsrAddrWidth-1:0] AM_NUM_PRED_ADDR      = 6'd1;
  parameter logic [CsrAddrWidth-1:0] AM_PRED_ADDR          = 6'd2;
  parameter logic [CsrAddrWidth-1:0] DATA_SRC_CTRL_ADDR    = 6'd3;
  parameter logic [CsrAddrWidth-1:0] SLICE_NUM_ELEM_A_ADDR = 6'd4;
  parameter logic [CsrAddrWidth-1:0] SLICE_NUM_ELEM_B_ADDR = 6'd5;
  parameter logic [CsrAddrWidth-1:0] AUTO_START_A_ADDR     = 6'd6;
  parameter logic [CsrAddrWidth-1:0] AUTO_START_B_ADDR     = 6'd7;
  parameter logic [CsrAddrWidth-1:0] AUTO_NUM_A_ADDR       = 6'd8;
  parameter logic [CsrAddrWidth-1:0] AUTO_NUM_B_ADDR       = 6'd9;
  parameter logic [CsrAddrWidth-1:0] OBSERVABLE_ADDR       = 6'd10;

  // Valid flag on read, valid clear on write
  parameter int unsigned AM_PRED_VALID_BIT = 8;

  // ----------------------------------------------------------
  // Core settings word, seen from the write side
  // ----------------------------------------------------------
  typedef struct packed {
    logic [CsrDataWidth-11:0] pad;
    logic                     slicer_clr;  // [9]
    logic                     regs_clr;    // [8]
    logic                     fifo_clr;    // [7]
    logic                     core_clr;    // [6]
    logic                     port_b_mux;  // [5]
    logic [1:0]               port_a_mux;  // [4:3]
    logic                     seq_test;    // [2]
    logic                     unused;      // [1]
    logic                     start;       // [0]
  } core_set_wr_t;

  // Same word on reads, commands are write-only
  typedef struct packed {
    logic [CsrDataWidth-11:0] pad;
    logic [3:0]               cmd_zero;    // [9:6]
    logic                     port_b_mux;
    logic [1:0]               port_a_mux;
    logic                     seq_test;
    logic                     busy;        // [1]
    logic                     start_zero;  // [0]
  } core_set_rd_t;

  typedef union packed {
    core_set_wr_t wr;
    core_set_rd_t rd;
  } core_set_u;

endpackage

`default_nettype wire

/* hw/csr_bus_port.sv */
`default_nettype none

module csr_bus_port (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // Request side
  input  wire logic                                  req_valid_i,
  input  wire logic                                  req_write_i,
  output logic                                       req_ready_o,
  output logic                                       wr_en_o,
  // Read data from the register file
  input  wire logic [csr_addr_pkg::CsrDataWidth-1:0] rd_data_i,
  // Response side
  output logic      [csr_addr_pkg::CsrDataWidth-1:0] rsp_data_o,
  output logic                                       rsp_valid_o,
  input  wire logic                                  rsp_ready_i
);

  logic req_acc;
  logic rd_req;

  logic                                  hold_valid_q;
  logic [csr_addr_pkg::CsrDataWidth-1:0] hold_data_q;

  // Never back-pressures the host
  assign req_ready_o = 1'b1;

  assign req_acc = req_valid_i & req_ready_o;
  assign wr_en_o = req_acc & req_write_i;
  assign rd_req  = req_acc & ~req_write_i;

  // ----------------------------------------------------------
  // Response holding register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (rd_req && !rsp_ready_i) begin
      hold_valid_q <= 1'b1;  // Host not ready, park it
    end else if (rsp_ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  // A newer read overwrites whatever is parked
  always_ff @(posedge clk_i) begin
    if (rd_req && !rsp_ready_i) begin
      hold_data_q <= rd_data_i;
    end
  end

  // Fresh read passes straight through
  assign rsp_valid_o = rd_req | hold_valid_q;
  assign rsp_data_o  = rd_req ? rd_data_i : hold_data_q;

endmodule

`default_nettype wire

/* hw/csr_ctrl_pkg.sv */
`default_nettype none

package csr_ctrl_pkg;

  // ----------------------------------------------------------
  // Host request
  // ----------------------------------------------------------
  typedef struct packed {
    logic [csr_addr_pkg::CsrAddrWidth-1:0] addr;
    logic [csr_addr_pkg::CsrDataWidth-1:0] data;
    logic                                  write;
  } csr_req_t;

  // ----------------------------------------------------------
  // Control towards the core
  // ----------------------------------------------------------
  typedef struct packed {
    logic       start;          // Pulse
    logic       seq_test_mode;
    logic [1:0] port_a_cim;
    logic       port_b_cim;
    logic       clr;            // Pulse
    logic       fifo_clr;       // Pulse
    logic       regs_clr;       // Pulse
    logic       dslc_clr;       // Pulse
  } core_ctrl_t;

  // Slicer and data source setup
  typedef struct packed {
    logic [1:0]                            slice_mode_a;
    logic [1:0]                            slice_mode_b;
    logic [1:0]                            src_sel;
    logic [csr_addr_pkg::CsrDataWidth-1:0] num_elem_a;
    logic [csr_addr_pkg::CsrDataWidth-1:0] num_elem_b;
    logic [csr_addr_pkg::CsrDataWidth-1:0] auto_start_a;
    logic [csr_addr_pkg::CsrDataWidth-1:0] auto_start_b;
    logic [csr_addr_pkg::CsrDataWidth-1:0] auto_num_a;
    logic [csr_addr_pkg::CsrDataWidth-1:0] auto_num_b;
  } data_src_cfg_t;

  // ----------------------------------------------------------
  // Run progress as seen in the observable register
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    OBS_IDLE = 2'b00,
    OBS_RUN  = 2'b01,
    OBS_DONE = 2'b11
  } obs_state_e;

endpackage

`default_nettype wire

/* hw/csr_obs_fsm.sv */
`default_nettype none

module csr_obs_fsm (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire csr_ctrl_pkg::core_ctrl_t core_ctrl_i,
  input  wire logic                     busy_i,
  output csr_ctrl_pkg::obs_state_e      state_o
);

  csr_ctrl_pkg::obs_state_e state_q;
  csr_ctrl_pkg::obs_state_e state_d;

  // ----------------------------------------------------------
  // Next state, first match wins
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    if (core_ctrl_i.start) begin
      state_d = csr_ctrl_pkg::OBS_RUN;
    end else if (state_q == csr_ctrl_pkg::OBS_RUN && !busy_i) begin
      state_d = csr_ctrl_pkg::OBS_DONE;  // Core went quiet
    end else if (core_ctrl_i.clr) begin
      state_d = csr_ctrl_pkg::OBS_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= csr_ctrl_pkg::OBS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

/* hw/csr_reg_file.sv */
`default_nettype none

module csr_reg_file #(
  parameter int unsigned AmPredWidth = 8
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire csr_ctrl_pkg::csr_req_t                req_i,
  input  wire logic                                  wr_en_i,
  output logic      [csr_addr_pkg::CsrDataWidth-1:0] rd_data_o,
  // Status from the core
  input  wire logic                                  busy_i,
  input  wire logic [AmPredWidth-1:0]                am_pred_i,
  input  wire logic                                  am_pred_valid_i,
  input  wire csr_ctrl_pkg::obs_state_e              obs_state_i,
  // Control to the core
  output csr_ctrl_pkg::core_ctrl_t                   core_ctrl_o,
  output csr_ctrl_pkg::data_src_cfg_t                data_src_cfg_o,
  output logic      [csr_addr_pkg::CsrDataWidth-1:0] am_num_pred_o,
  output logic                                       am_pred_valid_clr_o,
  output logic      [3:0]                            obs_logic_o
);

  localparam int unsigned W         = csr_addr_pkg::CsrDataWidth;
  localparam int unsigned FirstWord = csr_addr_pkg::SLICE_NUM_ELEM_A_ADDR;
  localparam int unsigned LastWord  = csr_addr_pkg::AUTO_NUM_B_ADDR;

  logic            core_wr;
  csr_addr_pkg::core_set_u wr_word;
  csr_addr_pkg::core_set_u rd_word;

  // ----------------------------------------------------------
  // Storage, implemented bits only
  // ----------------------------------------------------------
  logic [3:0]   core_set_q;  // Bits [5:2] of core settings
  logic [W-1:0] am_num_pred_q;
  logic [5:0]   src_ctrl_q;
  logic [W-1:0] cfg_word_q [FirstWord:LastWord];
  logic [1:0]   obs_low_q;

  assign wr_word = req_i.data;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_set_q    <= '0;
      am_num_pred_q <= '0;
      src_ctrl_q    <= '0;
      obs_low_q     <= '0;
      for (int i = FirstWord; i <= LastWord; i++) begin
        cfg_word_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      case (req_i.addr)
        csr_addr_pkg::CORE_SET_ADDR: begin
          core_set_q <= {wr_word.wr.port_b_mux, wr_word.wr.port_a_mux, wr_word.wr.seq_test};
        end
        csr_addr_pkg::AM_NUM_PRED_ADDR:   am_num_pred_q <= req_i.data;
        csr_addr_pkg::DATA_SRC_CTRL_ADDR: src_ctrl_q    <= req_i.data[5:0];
        csr_addr_pkg::SLICE_NUM_ELEM_A_ADDR,
        csr_addr_pkg::SLICE_NUM_ELEM_B_ADDR,
        csr_addr_pkg::AUTO_START_A_ADDR,
        csr_addr_pkg::AUTO_START_B_ADDR,
        csr_addr_pkg::AUTO_NUM_A_ADDR,
        csr_addr_pkg::AUTO_NUM_B_ADDR: begin
          cfg_word_q[req_i.addr] <= req_i.data;
        end
        csr_addr_pkg::OBSERVABLE_ADDR:    obs_low_q     <= req_i.data[1:0];
        default: ;  // AM prediction is read-only
      endcase
    end
  end

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------
  always_comb begin
    rd_word               = '0;
    rd_word.rd.busy       = busy_i;
    rd_word.rd.seq_test   = core_set_q[0];
    rd_word.rd.port_a_mux = core_set_q[2:1];
    rd_word.rd.port_b_mux = core_set_q[3];
  end

  always_comb begin
    rd_data_o = '0;
    case (req_i.addr)
      csr_addr_pkg::CORE_SET_ADDR:      rd_data_o = rd_word;
      csr_addr_pkg::AM_NUM_PRED_ADDR:   rd_data_o = am_num_pred_q;
      csr_addr_pkg::AM_PRED_ADDR: begin
        rd_data_o[csr_addr_pkg::AM_PRED_VALID_BIT] = am_pred_valid_i;
        rd_data_o[AmPredWidth-1:0]                 = am_pred_i;
      end
      csr_addr_pkg::DATA_SRC_CTRL_ADDR: rd_data_o[5:0] = src_ctrl_q;
      csr_addr_pkg::SLICE_NUM_ELEM_A_ADDR,
      csr_addr_pkg::SLICE_NUM_ELEM_B_ADDR,
      csr_addr_pkg::AUTO_START_A_ADDR,
      csr_addr_pkg::AUTO_START_B_ADDR,
      csr_addr_pkg::AUTO_NUM_A_ADDR,
      csr_addr_pkg::AUTO_NUM_B_ADDR:    rd_data_o = cfg_word_q[req_i.addr];
      csr_addr_pkg::OBSERVABLE_ADDR:    rd_data_o[3:0] = obs_logic_o;
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // Control outputs
  // ----------------------------------------------------------
  assign core_wr = wr_en_i & (req_i.addr == csr_addr_pkg::CORE_SET_ADDR);

  always_comb begin
    core_ctrl_o.start         = core_wr & wr_word.wr.start;
    core_ctrl_o.seq_test_mode = core_set_q[0];
    core_ctrl_o.port_a_cim    = core_set_q[2:1];
    core_ctrl_o.port_b_cim    = core_set_q[3];
    core_ctrl_o.clr           = core_wr & wr_word.wr.core_clr;
    core_ctrl_o.fifo_clr      = core_wr & wr_word.wr.fifo_clr;
    core_ctrl_o.regs_clr      = core_wr & wr_word.wr.regs_clr;
    core_ctrl_o.dslc_clr      = core_wr & wr_word.wr.slicer_clr;
  end

  always_comb begin
    data_src_cfg_o.slice_mode_a = src_ctrl_q[1:0];
    data_src_cfg_o.slice_mode_b = src_ctrl_q[3:2];
    data_src_cfg_o.src_sel      = src_ctrl_q[5:4];
    data_src_cfg_o.num_elem_a   = cfg_word_q[csr_addr_pkg::SLICE_NUM_ELEM_A_ADDR];
    data_src_cfg_o.num_elem_b   = cfg_word_q[csr_addr_pkg::SLICE_NUM_ELEM_B_ADDR];
    data_src_cfg_o.auto_start_a = cfg_word_q[csr_addr_pkg::AUTO_START_A_ADDR];
    data_src_cfg_o.auto_start_b = cfg_word_q[csr_addr_pkg::AUTO_START_B_ADDR];
    data_src_cfg_o.auto_num_a   = cfg_word_q[csr_addr_pkg::AUTO_NUM_A_ADDR];
    data_src_cfg_o.auto_num_b   = cfg_word_q[csr_addr_pkg::AUTO_NUM_B_ADDR];
  end

  assign am_num_pred_o       = am_num_pred_q;
  assign am_pred_valid_clr_o = wr_en_i & (req_i.addr == csr_addr_pkg::AM_PRED_ADDR)
                               & req_i.data[csr_addr_pkg::AM_PRED_VALID_BIT];

  // State on top of the writable low bits
  assign obs_logic_o = {obs_state_i, obs_low_q};

endmodule

`default_nettype wire

/* hw/csr_top.sv */
`default_nettype none

module csr_top #(
  parameter int unsigned AmPredWidth = 8
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // Request channel
  input  wire csr_ctrl_pkg::csr_req_t                req_i,
  input  wire logic                                  req_valid_i,
  output logic                                       req_ready_o,
  // Response channel
  output logic      [csr_addr_pkg::CsrDataWidth-1:0] rsp_data_o,
  output logic                                       rsp_valid_o,
  input  wire logic                                  rsp_ready_i,
  // Core status
  input  wire logic                                  busy_i,
  input  wire logic [AmPredWidth-1:0]                am_pred_i,
  input  wire logic                                  am_pred_valid_i,
  // Core control
  output csr_ctrl_pkg::core_ctrl_t                   core_ctrl_o,
  output csr_ctrl_pkg::data_src_cfg_t                data_src_cfg_o,
  output logic      [csr_addr_pkg::CsrDataWidth-1:0] am_num_pred_o,
  output logic                                       am_pred_valid_clr_o,
  output logic      [3:0]                            obs_logic_o
);

  logic                                  wr_en;
  logic [csr_addr_pkg::CsrDataWidth-1:0] rd_data;
  csr_ctrl_pkg::obs_state_e              obs_state;

  // ----------------------------------------------------------
  // Handshake and response buffering
  // ----------------------------------------------------------
  csr_bus_port u_bus_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_write_i (req_i.write),
    .req_ready_o (req_ready_o),
    .wr_en_o     (wr_en),
    .rd_data_i   (rd_data),
    .rsp_data_o  (rsp_data_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  csr_reg_file #(
    .AmPredWidth (AmPredWidth)
  ) u_reg_file (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .wr_en_i             (wr_en),
    .rd_data_o           (rd_data),
    .busy_i              (busy_i),
    .am_pred_i           (am_pred_i),
    .am_pred_valid_i     (am_pred_valid_i),
    .obs_state_i         (obs_state),
    .core_ctrl_o         (core_ctrl_o),
    .data_src_cfg_o      (data_src_cfg_o),
    .am_num_pred_o       (am_num_pred_o),
    .am_pred_valid_clr_o (am_pred_valid_clr_o),
    .obs_logic_o         (obs_logic_o)
  );

  // Progress tracker fed by the pulses
  csr_obs_fsm u_obs_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_ctrl_i (core_ctrl_o),
    .busy_i      (busy_i),
    .state_o     (obs_state)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CSR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module csr_tb \
  -o csr_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/csr_sim > sim.log 2>&1

grep -q "Some tests failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "All tests passed" sim.log && echo "Simulation passed" \
  || { echo "Simulation ended without a result, see sim.log"; exit 1; }

/* tests/csr_properties.sv */
`default_nettype none

module csr_properties (
  input wire logic                     clk_i,
  input wire logic                     rst_ni,
  input wire csr_ctrl_pkg::csr_req_t   req_i,
  input wire logic                     req_valid_i,
  input wire logic                     req_ready_o,
  input wire logic                     rsp_valid_o,
  input wire logic                     rsp_ready_i,
  input wire csr_ctrl_pkg::core_ctrl_t core_ctrl_o
);

  logic any_pulse;

  assign any_pulse = core_ctrl_o.start | core_ctrl_o.clr | core_ctrl_o.fifo_clr
                   | core_ctrl_o.regs_clr | core_ctrl_o.dslc_clr;

  // ----------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------
  ready_always: assert property (@(posedge clk_i) disable iff (!rst_ni) req_ready_o)
    else $error("req_ready_o low outside reset");

  rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_o && !rsp_ready_i) |=> rsp_valid_o)
    else $error("rsp_valid_o dropped before the host took the response");

  // Pulses only come from an accepted write
  pulse_from_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_pulse |-> (req_valid_i && req_ready_o && req_i.write))
    else $error("Command pulse without an accepted write");

  no_rsp_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !rsp_valid_o)
    else $error("rsp_valid_o high during reset");

endmodule

`default_nettype wire

/* tests/csr_tb.sv */
`default_nettype none

module csr_tb;

  localparam int unsigned ClkPeriod = 8;

  typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} op_e;

  // One cycle of host activity and what the DUT must show in it
  typedef struct packed {
    op_e         op;
    logic [5:0]  addr;
    logic [31:0] data;
    logic        busy;
    logic [7:0]  am_pred;
    logic        am_valid;
    logic        rsp_ready;
    logic        exp_valid;
    logic [31:0] exp_data;
    logic [5:0]  exp_pulse;  // {am clr, slicer, regs, fifo, core clr, start}
  } step_t;

  logic                        clk_i;
  logic                        rst_ni;
  csr_ctrl_pkg::csr_req_t      req;
  logic                        req_valid;
  logic                        req_ready;
  logic [31:0]                 rsp_data;
  logic                        rsp_valid;
  logic                        rsp_ready;
  logic                        busy;
  logic [7:0]                  am_pred;
  logic                        am_pred_valid;
  csr_ctrl_pkg::core_ctrl_t    core_ctrl;
  csr_ctrl_pkg::data_src_cfg_t data_src_cfg;
  logic [31:0]                 am_num_pred;
  logic                        am_pred_valid_clr;
  logic [3:0]                  obs_logic;

  step_t       steps[$];
  logic [31:0] shadow [0:10];  // Expected full-word contents
  logic [31:0] src_word;
  int          seed;
  logic        table_ready;

  csr_top #(
    .AmPredWidth (8)
  ) dut_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req),
    .req_valid_i         (req_valid),
    .req_ready_o         (req_ready),
    .rsp_data_o          (rsp_data),
    .rsp_valid_o         (rsp_valid),
    .rsp_ready_i         (rsp_ready),
    .busy_i              (busy),
    .am_pred_i           (am_pred),
    .am_pred_valid_i     (am_pred_valid),
    .core_ctrl_o         (core_ctrl),
    .data_src_cfg_o      (data_src_cfg),
    .am_num_pred_o       (am_num_pred),
    .am_pred_valid_clr_o (am_pred_valid_clr),
    .obs_logic_o         (obs_logic)
  );

  bind csr_top csr_properties u_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .core_ctrl_o (core_ctrl_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic add_step(input op_e op, input logic [5:0] addr, input logic [31:0] data,
                          input logic bsy, input logic [7:0] pred, input logic pvalid,
                          input logic rready, input logic exp_valid,
                          input logic [31:0] exp_data, input logic [5:0] exp_pulse);
    steps.push_back({op, addr, data, bsy, pred, pvalid, rready, exp_valid, exp_data,
                     exp_pulse});
  endtask

  task automatic add_write(input logic [5:0] addr, input logic [31:0] data, input logic bsy,
                           input logic [5:0] pulse);
    add_step(OP_WRITE, addr, data, bsy, 8'h0, 1'b0, 1'b1, 1'b0, 32'h0, pulse);
  endtask

  task automatic add_read(input logic [5:0] addr, input logic bsy, input logic rready,
                          input logic [31:0] exp);
    add_step(OP_READ, addr, 32'h0, bsy, 8'h0, 1'b0, rready, 1'b1, exp, 6'h0);
  endtask

  task automatic add_idle(input logic bsy, input logic rready, input logic exp_valid,
                          input logic [31:0] exp);
    add_step(OP_IDLE, 6'h0, 32'h0, bsy, 8'h0, 1'b0, rready, exp_valid, exp, 6'h0);
  endtask

  // Busy at bit 1, stored fields at [5:2], commands read as zero
  function automatic logic [31:0] core_rd(input logic [31:0] wr_data, input logic bsy);
    return (wr_data & 32'h0000_003C) | {30'h0, bsy, 1'b0};
  endfunction

  function automatic logic [31:0] obs_rd(input logic [1:0] state, input logic [1:0] low);
    return {28'h0, state, low};
  endfunction

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  task automatic build_table();
    int full_regs [7] = '{1, 4, 5, 6, 7, 8, 9};
    // Reset values
    for (int a = 0; a <= 10; a++) begin
      add_read(a[5:0], 1'b1, 1'b1, (a == 0) ? 32'h2 : 32'h0);
    end
    // Random words, then an unmapped write that must not land anywhere
    foreach (full_regs[i]) begin
      shadow[full_regs[i]] = $random(seed);
      add_write(full_regs[i][5:0], shadow[full_regs[i]], 1'b0, 6'h0);
    end
    src_word = $random(seed);
    add_write(6'd3, src_word, 1'b0, 6'h0);
    add_write(6'd11, $random(seed), 1'b0, 6'h0);
    foreach (full_regs[i]) add_read(full_regs[i][5:0], 1'b0, 1'b1, shadow[full_regs[i]]);
    add_read(6'd3, 1'b0, 1'b1, src_word & 32'h3F);
    add_read(6'd11, 1'b0, 1'b1, 32'h0);
    add_read(6'd63, 1'b0, 1'b1, 32'h0);
    // All commands at once, pulses for one cycle only
    add_write(6'd0, 32'h3EF, 1'b0, 6'b011111);
    add_idle(1'b0, 1'b1, 1'b0, 32'h0);
    add_read(6'd0, 1'b0, 1'b1, core_rd(32'h3EF, 1'b0));
    // AM prediction
    add_step(OP_READ, 6'd2, 32'h0, 1'b0, 8'hA5, 1'b1, 1'b1, 1'b1, 32'h1A5, 6'h0);
    add_step(OP_READ, 6'd2, 32'h0, 1'b0, 8'h3C, 1'b0, 1'b1, 1'b1, 32'h03C, 6'h0);
    add_write(6'd2, 32'h100, 1'b0, 6'b100000);
    add_write(6'd2, 32'h0FF, 1'b0, 6'h0);
    add_step(OP_READ, 6'd2, 32'h0, 1'b0, 8'h5A, 1'b1, 1'b1, 1'b1, 32'h15A, 6'h0);
    // Back-pressure, second read replaces the held word
    add_read(6'd1, 1'b0, 1'b0, shadow[1]);
    add_idle(1'b0, 1'b0, 1'b1, shadow[1]);
    add_idle(1'b0, 1'b0, 1'b1, shadow[1]);
    add_read(6'd4, 1'b0, 1'b0, shadow[4]);
    add_idle(1'b0, 1'b0, 1'b1, shadow[4]);
    add_idle(1'b0, 1'b1, 1'b1, shadow[4]);
    add_idle(1'b0, 1'b1, 1'b0, 32'h0);
    // Observable register, state is DONE since the earlier start
    add_write(6'd10, 32'hFFFF_FFFE, 1'b0, 6'h0);
    add_read(6'd10, 1'b0, 1'b1, obs_rd(2'b11, 2'b10));
    add_write(6'd0, 32'h2D, 1'b1, 6'b000001);
    add_read(6'd10, 1'b1, 1'b1, obs_rd(2'b01, 2'b10));
    add_idle(1'b0, 1'b1, 1'b0, 32'h0);
    add_read(6'd10, 1'b0, 1'b1, obs_rd(2'b11, 2'b10));
    add_write(6'd0, 32'h6C, 1'b0, 6'b000010);
    add_read(6'd10, 1'b0, 1'b1, obs_rd(2'b00, 2'b10));
    add_write(6'd10, 32'h1, 1'b0, 6'h0);
    add_read(6'd10, 1'b0, 1'b1, obs_rd(2'b00, 2'b01));
    add_read(6'd0, 1'b0, 1'b1, core_rd(32'h6C, 1'b0));
  endtask

  task automatic apply_step(input step_t s);
    req_valid     = (s.op != OP_IDLE);
    req.write     = (s.op == OP_WRITE);
    req.addr      = s.addr;
    req.data      = s.data;
    busy          = s.busy;
    am_pred       = s.am_pred;
    am_pred_valid = s.am_valid;
    rsp_ready     = s.rsp_ready;
  endtask

  task automatic check_step(input step_t s);
    check_val("req_ready_o", {31'h0, req_ready}, 32'h1);
    check_val("rsp_valid_o", {31'h0, rsp_valid}, {31'h0, s.exp_valid});
    if (s.exp_valid) check_val("rsp_data_o", rsp_data, s.exp_data);
    check_val("pulses", {26'h0, am_pred_valid_clr, core_ctrl.dslc_clr, core_ctrl.regs_clr,
              core_ctrl.fifo_clr, core_ctrl.clr, core_ctrl.start}, {26'h0, s.exp_pulse});
    if (s.op == OP_READ && s.addr == 6'd10) begin
      check_val("obs_logic_o", {28'h0, obs_logic}, s.exp_data);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_ni        = 1'b0;
    req           = '0;
    req_valid     = 1'b0;
    rsp_ready     = 1'b1;
    busy          = 1'b0;
    am_pred       = 8'h0;
    am_pred_valid = 1'b0;
    table_ready   = 1'b0;
    seed          = 32'h333d5e48;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    #1;
    check_val("core_ctrl_o", {23'h0, core_ctrl}, 32'h0);
    check_val("data_src_cfg_o nonzero", {31'h0, |data_src_cfg}, 32'h0);
    check_val("am_num_pred_o", am_num_pred, 32'h0);
    check_val("obs_logic_o", {28'h0, obs_logic}, 32'h0);
    foreach (steps[i]) begin
      @(posedge clk_i);
      #1 apply_step(steps[i]);
      #5 check_step(steps[i]);
    end
    @(posedge clk_i);
    #1 req_valid = 1'b0;
    // Outputs after the whole table
    check_val("am_num_pred_o", am_num_pred, shadow[1]);
    check_val("num_elem_a", data_src_cfg.num_elem_a, shadow[4]);
    check_val("num_elem_b", data_src_cfg.num_elem_b, shadow[5]);
    check_val("auto_start_a", data_src_cfg.auto_start_a, shadow[6]);
    check_val("auto_start_b", data_src_cfg.auto_start_b, shadow[7]);
    check_val("auto_num_a", data_src_cfg.auto_num_a, shadow[8]);
    check_val("auto_num_b", data_src_cfg.auto_num_b, shadow[9]);
    check_val("slice_mode_a", {30'h0, data_src_cfg.slice_mode_a}, {30'h0, src_word[1:0]});
    check_val("slice_mode_b", {30'h0, data_src_cfg.slice_mode_b}, {30'h0, src_word[3:2]});
    check_val("src_sel", {30'h0, data_src_cfg.src_sel}, {30'h0, src_word[5:4]});
    check_val("seq_test_mode", {31'h0, core_ctrl.seq_test_mode}, 32'h1);  // From 0x6C
    check_val("port_a_cim", {30'h0, core_ctrl.port_a_cim}, 32'h1);
    check_val("port_b_cim", {31'h0, core_ctrl.port_b_cim}, 32'h1);
    $display("All tests passed");
    $finish;
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (steps.size() * 20 + 8) @(posedge clk_i);
    $display("Run timed out before the stimulus table finished");
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/csr_addr_pkg.sv
hw/csr_ctrl_pkg.sv
hw/csr_bus_port.sv
hw/csr_reg_file.sv
hw/csr_obs_fsm.sv
hw/csr_top.sv
tests/csr_properties.sv
tests/csr_tb.sv
